// File: Bender.yml
package:
  name: tutor_loader

export_include_dirs:
  - .

sources:
  - tutor_pkg.sv
  - rom_identify.sv
  - bank_config.sv
  - cart_eraser.sv
  - ram_load_port.sv
  - core_reset_gen.sv
  - tutor_loader_top.sv
  - target: test
    files:
      - tb_tutor_loader.sv

// File: bank_config.sv
/*
 * Developer RAM bank configuration
 * ALT+F11 toggles the hidden developer enable; the requested banks pass
 * only while it is set, and cartridge RAM forces banks 6000 and C000
 */

`timescale 1ns/100ps
`default_nettype none

`include "tutor_loader_cfg.svh"

module bank_config import tutor_pkg::*; (
	input  wire             clk_sys,
	input  wire             RESET,
	input  wire key_event_t key_i,
	input  wire bank_en_t   bank_req_i,
	input  wire             cart_ram_en_i,
	output bank_en_t        bank_en_o
);

	logic     toggle_q;
	logic     key_evt;
	logic     alt_held;
	logic     dev_en;
	bank_en_t dev_banks;
	bank_en_t cart_banks;

	// Previous toggle level for event detect
	always_ff @(posedge clk_sys) begin
		toggle_q <= key_i.toggle;
	end

	assign key_evt = (key_i.toggle != toggle_q);

	//////////////////////////////////////////////////
	// Hotkey tracking
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			alt_held <= 1'b0;
			dev_en   <= 1'b0;
		end else if (key_evt) begin
			// ALT level follows press and release
			if (key_i.code == `KEY_ALT)
				alt_held <= key_i.pressed;
			// F11 release is ignored
			if (key_i.code == `KEY_F11 && alt_held && key_i.pressed)
				dev_en <= ~dev_en;
		end
	end

	// Menu request only counts with the developer enable set
	assign dev_banks = dev_en ? bank_req_i : '0;

	// Banks 6000 and C000 carry the cartridge RAM
	assign cart_banks = {cart_ram_en_i, 2'b00, cart_ram_en_i, 1'b0};

	assign bank_en_o = dev_banks | cart_banks;

endmodule

`default_nettype wire

// File: cart_eraser.sv
/*
 * Cartridge RAM eraser
 * On a rising eject request, writes a zero byte every second cycle over
 * region A and then region B, in ascending address order
 */

`timescale 1ns/100ps
`default_nettype none

`include "tutor_loader_cfg.svh"

module cart_eraser import tutor_pkg::*; (
	input  wire     clk_sys,
	input  wire     RESET,
	input  wire     eject_req_i,
	output ram_wr_t erase_wr_o,
	output logic    erasing_o
);

	erase_state_e state_q;
	byte_addr_t   addr_q;
	logic         eject_q;
	logic         eject_rise;

	// Eject request edge detect
	always_ff @(posedge clk_sys) begin
		eject_q <= eject_req_i;
	end

	assign eject_rise = eject_req_i && !eject_q;

	//////////////////////////////////////////////////
	// Erase FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state_q <= ER_IDLE;
		end else begin
			case (state_q)
				ER_IDLE: begin
					if (eject_rise)
						state_q <= ER_WRITE;
				end
				// One write cycle, then one quiet cycle
				ER_WRITE: state_q <= ER_GAP;
				ER_GAP: begin
					if (addr_q == `ERASE_B_HI)
						state_q <= ER_IDLE;
					else
						state_q <= ER_WRITE;
				end
				default: state_q <= ER_IDLE;
			endcase
		end
	end

	// Address walk, A region then jump to B
	always_ff @(posedge clk_sys) begin
		if (state_q == ER_IDLE && eject_rise)
			addr_q <= `ERASE_A_LO;
		else if (state_q == ER_GAP) begin
			if (addr_q == `ERASE_A_HI)
				addr_q <= `ERASE_B_LO;
			else
				addr_q <= addr_q + 17'd1;
		end
	end

	always_comb begin
		erase_wr_o.we   = (state_q == ER_WRITE);
		erase_wr_o.addr = addr_q;
		erase_wr_o.data = 8'h00;
	end

	// Busy for the whole walk, gap cycles included
	assign erasing_o = (state_q != ER_IDLE);

endmodule

`default_nettype wire

// File: core_reset_gen.sv
/*
 * Core reset generator
 * Merges reset sources and stretches reset after downloads and erase;
 * holds the core in reset while no valid system ROM is loaded
 */

`timescale 1ns/100ps
`default_nettype none

`include "tutor_loader_cfg.svh"

module core_reset_gen (
	input  wire  clk_sys,
	input  wire  RESET,
	input  wire  reset_req_i,
	input  wire  download_i,
	input  wire  erasing_i,
	input  wire  rom_valid_i,
	output logic core_reset_o
);

	logic       trigger;
	logic [7:0] stretch_q;

	assign trigger = RESET || reset_req_i || download_i || erasing_i;

	// Reload while any source is active, count down afterwards
	always_ff @(posedge clk_sys) begin
		if (trigger)
			stretch_q <= `DL_RESET_CYCLES;
		else if (stretch_q != 8'd0)
			stretch_q <= stretch_q - 8'd1;
	end

	assign core_reset_o = trigger || (stretch_q != 8'd0) || !rom_valid_i;

endmodule

`default_nettype wire

// File: ram_load_port.sv
/*
 * RAM write port mux
 * Maps download bytes to RAM byte addresses with the endian swap and
 * cartridge offset; the eraser takes the port while it runs
 */

`timescale 1ns/100ps
`default_nettype none

`include "tutor_loader_cfg.svh"

module ram_load_port import tutor_pkg::*; (
	input  wire load_port_t load_i,
	input  wire ram_wr_t    erase_wr_i,
	input  wire             erasing_i,
	output ram_wr_t         ram_wr_o
);

	byte_addr_t swap_addr;
	byte_addr_t dl_addr;

	// Byte swap inside each 16-bit word
	assign swap_addr = {load_i.addr[16:1], ~load_i.addr[0]};

	// Cartridge images land above 64K
	assign dl_addr = (load_i.index == `IDX_CART) ? swap_addr + `CART_BYTE_OFFSET : swap_addr;

	always_comb begin
		if (erasing_i) begin
			// Downloads dropped while erasing
			ram_wr_o = erase_wr_i;
		end else begin
			ram_wr_o.we   = load_i.download && load_i.wr;
			ram_wr_o.addr = dl_addr;
			ram_wr_o.data = load_i.data;
		end
	end

endmodule

`default_nettype wire

// File: rom_identify.sv
/*
 * System ROM identification and cartridge checks
 * Sums data bit 0 over the system ROM to pick Tutor, Pyuta or Pyuta Jr,
 * tracks the cartridge's last address and the 24K ROM+RAM check counter
 */

`timescale 1ns/100ps
`default_nettype none

`include "tutor_loader_cfg.svh"

module rom_identify import tutor_pkg::*; (
	input  wire        clk_sys,
	input  wire        RESET,
	input  wire        load_port_t load_i,
	output sys_type_e  sys_type_o,
	output logic       rom_valid_o,
	output byte_addr_t cart_last_o,
	output logic       cart_ram_en_o
);

	logic       sys_stb;
	logic       cart_stb;
	logic       addr_zero;
	logic       in_window;
	logic       hash_ok;
	rom_hash_t  hash_q;
	chk24_t     chk24_q;
	byte_addr_t cart_last_q;

	// Strobes per download target
	assign sys_stb = load_i.download && load_i.wr &&
		(load_i.index == `IDX_SYS_ROM0 || load_i.index == `IDX_SYS_ROM1);
	assign cart_stb = load_i.download && load_i.wr && (load_i.index == `IDX_CART);

	// First byte of a file restarts the sums
	assign addr_zero = (load_i.addr == '0);
	assign in_window = (load_i.addr >= `CHK24_LO) && (load_i.addr <= `CHK24_HI);

	assign hash_ok = (hash_q == `HASH_TUTOR) || (hash_q == `HASH_PYUTA) ||
		(hash_q == `HASH_PYUTA_JR);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hash_q      <= '0;
			rom_valid_o <= 1'b0;
			chk24_q     <= '0;
			cart_last_q <= '0;
		end else begin
			if (sys_stb) begin
				if (addr_zero)
					hash_q <= rom_hash_t'(load_i.data[0]);
				else
					hash_q <= hash_q + rom_hash_t'(load_i.data[0]);
			end
			// Valid flag lags the checksum by one cycle
			rom_valid_o <= hash_ok;

			if (cart_stb) begin
				cart_last_q <= load_i.addr[16:0];
				// Address 0 lies outside the window, so clearing is enough
				if (addr_zero)
					chk24_q <= '0;
				else if (in_window)
					chk24_q <= chk24_q + chk24_t'(load_i.data[0]);
			end
		end
	end

	// Machine decode straight from the running checksum
	always_comb begin
		case (hash_q)
			`HASH_TUTOR:    sys_type_o = SYS_TUTOR;
			`HASH_PYUTA:    sys_type_o = SYS_PYUTA;
			`HASH_PYUTA_JR: sys_type_o = SYS_PYUTA_JR;
			default:        sys_type_o = SYS_UNKNOWN;
		endcase
	end

	assign cart_last_o = cart_last_q;

	// Small carts, or a 32K image with an empty 2000-3FFF window, get 16K RAM
	assign cart_ram_en_o = (cart_last_q <= `CART_SMALL_MAX) || (chk24_q == '0);

endmodule

`default_nettype wire

// File: tb_tutor_loader.sv
/*
 * Testbench for the Tutor loader
 * Drives system-ROM and cartridge downloads, hotkey events and an eject,
 * and checks every RAM write, the machine decode, bank enables and reset
 */

`timescale 1ns/100ps
`default_nettype none

`include "tutor_loader_cfg.svh"

module tb_tutor_loader import tutor_pkg::*; ();

	//////////////////////////////////////////////////
	// Test lengths and run limit
	//////////////////////////////////////////////////

	localparam int ROM_CYCLES   = 4800 + 4300 + 4600;
	localparam int CART_CYCLES  = 2 * 32768;
	localparam int ERASE_WRITES = (`ERASE_A_HI - `ERASE_A_LO + 1) +
		(`ERASE_B_HI - `ERASE_B_LO + 1);
	localparam int HOLD_CYCLES  = 2 * `DL_RESET_CYCLES + 10;
	localparam int TEST_CYCLES  = ROM_CYCLES + CART_CYCLES + 2 * ERASE_WRITES +
		HOLD_CYCLES + 1000;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic        clk_sys;
	logic        RESET;
	load_port_t  load;
	key_event_t  key_ev;
	menu_req_t   menu;
	ram_wr_t     ram_wr;
	sys_type_e   sys_type;
	logic        rom_valid;
	byte_addr_t  cart_last;
	bank_en_t    bank_en;
	logic        erase_busy;
	logic        core_reset;

	integer      seed = 33;
	int          cycle_count = 0;
	// Expected writes as {addr, data}
	logic [24:0] exp_q[$];
	logic [24:0] exp_w;

	// Reference model state
	rom_hash_t   ref_hash = '0;
	chk24_t      ref_chk = '0;
	byte_addr_t  ref_last = '0;
	logic        ref_alt = 1'b0;
	logic        ref_dev = 1'b0;

	tutor_loader_top i_tutor_loader_top (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.load_i       (load),
		.key_i        (key_ev),
		.menu_i       (menu),
		.ram_wr_o     (ram_wr),
		.sys_type_o   (sys_type),
		.rom_valid_o  (rom_valid),
		.cart_last_o  (cart_last),
		.bank_en_o    (bank_en),
		.erase_busy_o (erase_busy),
		.core_reset_o (core_reset)
	);

	// 40 ns clock
	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// Reference functions
	//////////////////////////////////////////////////

	// RAM byte address of a download byte with bit 0 swapped and carts above 64K
	function automatic byte_addr_t ref_map_addr(input logic [7:0] index, input load_addr_t addr);
		byte_addr_t a;
		a = addr[16:0] ^ 17'h1;
		if (index == `IDX_CART)
			a = a + `CART_BYTE_OFFSET;
		return a;
	endfunction

	function automatic sys_type_e ref_sys_type(input rom_hash_t hash);
		case (hash)
			`HASH_TUTOR:    return SYS_TUTOR;
			`HASH_PYUTA:    return SYS_PYUTA;
			`HASH_PYUTA_JR: return SYS_PYUTA_JR;
			default:        return SYS_UNKNOWN;
		endcase
	endfunction

	// Developer banks gated while cartridge RAM forces banks 6000 and C000
	function automatic bank_en_t ref_bank(input bank_en_t req);
		logic     cart_ram;
		bank_en_t b;
		cart_ram = (ref_last <= `CART_SMALL_MAX) || (ref_chk == '0);
		b = ref_dev ? req : 5'b0;
		b[1] = b[1] | cart_ram;
		b[4] = b[4] | cart_ram;
		return b;
	endfunction

	//////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////

	task automatic stop_run();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch %s: got 0x%h, expected 0x%h", name, got, expected);
			stop_run();
		end
	endtask

	task automatic check_outputs();
		check_val("sys_type_o", sys_type, ref_sys_type(ref_hash));
		check_val("rom_valid_o", rom_valid, ref_sys_type(ref_hash) != SYS_UNKNOWN);
		check_val("cart_last_o", cart_last, ref_last);
		check_val("bank_en_o", bank_en, ref_bank(menu.bank_req));
		check_val("pending writes", exp_q.size(), 0);
	endtask

	// Writes sampled mid low phase away from both clock edges
	always begin
		@(negedge clk_sys);
		#10;
		if (!RESET && ram_wr.we === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("unexpected RAM write to address 0x%h", ram_wr.addr);
				stop_run();
			end else begin
				exp_w = exp_q.pop_front();
				check_val("ram_wr_o.addr", ram_wr.addr, exp_w[24:8]);
				check_val("ram_wr_o.data", ram_wr.data, exp_w[7:0]);
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the run did not finish", cycle_count);
			stop_run();
		end
	end

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////

	// One download byte with its expected write and model update
	task automatic send_byte(input logic [7:0] index, input load_addr_t addr, input logic [7:0] data);
		@(negedge clk_sys);
		load.download = 1'b1;
		load.wr       = 1'b1;
		load.index    = index;
		load.addr     = addr;
		load.data     = data;
		exp_q.push_back({ref_map_addr(index, addr), data});
		if (index == `IDX_SYS_ROM0 || index == `IDX_SYS_ROM1) begin
			ref_hash = (addr == '0) ? {15'd0, data[0]} : ref_hash + {15'd0, data[0]};
		end else if (index == `IDX_CART) begin
			ref_last = addr[16:0];
			if (addr == '0)
				ref_chk = '0;
			else if (addr >= `CHK24_LO && addr <= `CHK24_HI)
				ref_chk = ref_chk + {7'd0, data[0]};
		end
	endtask

	task automatic end_load();
		@(negedge clk_sys);
		load.download = 1'b0;
		load.wr       = 1'b0;
	endtask

	// Odd bytes scattered among even ones at random
	task automatic load_sys_rom(input logic [7:0] index, input int n_ones, input int n_evens);
		int         ones_left;
		int         evens_left;
		int         addr;
		logic [7:0] d;
		ones_left  = n_ones;
		evens_left = n_evens;
		for (addr = 0; addr < n_ones + n_evens; addr++) begin
			d = $random(seed);
			if (evens_left == 0 || (ones_left != 0 && d[7])) begin
				d[0] = 1'b1;
				ones_left--;
			end else begin
				d[0] = 1'b0;
				evens_left--;
			end
			send_byte(index, addr, d);
		end
		end_load();
	endtask

	// 32K image with an even check window or an odd byte every 64
	task automatic load_cart(input logic odd_window);
		int         addr;
		logic [7:0] d;
		for (addr = 0; addr < 32768; addr++) begin
			d = $random(seed);
			if (addr >= `CHK24_LO && addr <= `CHK24_HI)
				d[0] = odd_window && (addr % 64 == 0);
			send_byte(`IDX_CART, addr, d);
		end
		end_load();
	endtask

	// Key event with the bank enables checked one cycle later
	task automatic key_event(input logic [7:0] code, input logic pressed);
		@(negedge clk_sys);
		key_ev.toggle  = ~key_ev.toggle;
		key_ev.pressed = pressed;
		key_ev.code    = code;
		if (code == `KEY_ALT)
			ref_alt = pressed;
		if (code == `KEY_F11 && pressed && ref_alt)
			ref_dev = ~ref_dev;
		@(negedge clk_sys);
		check_val("bank_en_o", bank_en, ref_bank(menu.bank_req));
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin : stimulus
		int i;
		int a;
		int hi_cycles;
		RESET  = 1'b1;
		load   = '0;
		key_ev = '0;
		menu   = '0;
		repeat (4) @(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);

		// Idle after reset
		check_val("ram_wr_o.we", ram_wr.we, 1'b0);
		check_val("erase_busy_o", erase_busy, 1'b0);
		check_val("core_reset_o", core_reset, 1'b1);
		check_outputs();

		// Pyuta Jr ROM, 4391 odd bytes
		load_sys_rom(`IDX_SYS_ROM0, 4391, 409);
		repeat (2) @(negedge clk_sys);
		check_val("sys_type_o", sys_type, SYS_PYUTA_JR);
		check_outputs();

		// Unknown ROM keeps the core in reset
		load_sys_rom(`IDX_SYS_ROM0, 4000, 300);
		repeat (2) @(negedge clk_sys);
		check_val("sys_type_o", sys_type, SYS_UNKNOWN);
		check_outputs();
		for (i = 0; i < HOLD_CYCLES; i++) begin
			@(negedge clk_sys);
			check_val("core_reset_o", core_reset, 1'b1);
		end

		// Valid ROM again, then count the stretch from the download fall
		load_sys_rom(`IDX_SYS_ROM1, 4391, 209);
		hi_cycles = 1;
		@(negedge clk_sys);
		while (core_reset === 1'b1 && hi_cycles <= `DL_RESET_CYCLES) begin
			hi_cycles++;
			@(negedge clk_sys);
		end
		check_val("core_reset_o high cycles", hi_cycles, `DL_RESET_CYCLES);
		check_outputs();

		// 32K cartridge with an empty check window
		load_cart(1'b0);
		repeat (2) @(negedge clk_sys);
		check_val("bank_en_o", bank_en, 5'b10010);
		check_outputs();

		// Hidden developer banks
		@(negedge clk_sys);
		menu.bank_req = 5'h1F;
		@(negedge clk_sys);
		check_outputs();
		key_event(`KEY_F11, 1'b1);
		key_event(`KEY_F11, 1'b0);
		key_event(`KEY_ALT, 1'b1);
		key_event(`KEY_F11, 1'b1);
		check_val("bank_en_o", bank_en, 5'h1F);
		key_event(`KEY_F11, 1'b0);
		key_event(`KEY_ALT, 1'b0);
		key_event(`KEY_ALT, 1'b1);
		key_event(`KEY_F11, 1'b1);
		check_val("bank_en_o", bank_en, 5'b10010);
		key_event(`KEY_F11, 1'b0);
		key_event(`KEY_ALT, 1'b0);

		// 24K ROM+RAM cartridge drops the forced banks
		load_cart(1'b1);
		repeat (2) @(negedge clk_sys);
		check_val("bank_en_o", bank_en, 5'b00000);
		check_outputs();

		// Eject erase over both cartridge RAM regions
		for (a = `ERASE_A_LO; a <= `ERASE_A_HI; a++)
			exp_q.push_back({a[16:0], 8'h00});
		for (a = `ERASE_B_LO; a <= `ERASE_B_HI; a++)
			exp_q.push_back({a[16:0], 8'h00});
		@(negedge clk_sys);
		menu.eject_req = 1'b1;
		i = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk_sys);
			check_val("erase_busy_o", erase_busy, 1'b1);
			i++;
			// Stray strobes while the eraser owns the port
			load.download = (i < 200);
			load.wr       = (i < 200);
			load.index    = 8'd3;
			load.addr     = i;
			load.data     = $random(seed);
			if (i == 8)
				menu.eject_req = 1'b0;
		end
		load = '0;
		while (erase_busy === 1'b1)
			@(negedge clk_sys);
		@(negedge clk_sys);
		check_val("pending writes", exp_q.size(), 0);

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tutor_loader_cfg.svh
/*
 * Tutor loader configuration
 * Download indices, address windows, ROM checksums, hotkey scan codes
 * and the reset stretch length for the cartridge and system-ROM loader
 */

`ifndef TUTOR_LOADER_CFG_SVH
`define TUTOR_LOADER_CFG_SVH

// Download port indices
`define IDX_SYS_ROM0      8'd0
`define IDX_SYS_ROM1      8'd1
`define IDX_CART          8'd2

// Cartridge bytes sit above the 64K system space
`define CART_BYTE_OFFSET  17'h10000

// Bit 0 checksums of the known system ROMs
`define HASH_TUTOR        16'h2E8E
`define HASH_PYUTA        16'h23D7
`define HASH_PYUTA_JR     16'h1127

// 24K ROM+RAM check window, in download addresses
`define CHK24_LO          25'h0002000
`define CHK24_HI          25'h0003FFF
`define CART_SMALL_MAX    17'h04000

// Cartridge RAM regions cleared on eject
`define ERASE_A_LO        17'h0C000
`define ERASE_A_HI        17'h0DFFF
`define ERASE_B_LO        17'h10000
`define ERASE_B_HI        17'h18000

// PS/2 set 2 scan codes for the developer hotkey
`define KEY_ALT           8'h11
`define KEY_F11           8'h78

`define DL_RESET_CYCLES   8'd255

`endif

// File: tutor_loader_top.f
+incdir+.
tutor_pkg.sv
rom_identify.sv
bank_config.sv
cart_eraser.sv
ram_load_port.sv
core_reset_gen.sv
tutor_loader_top.sv
tb_tutor_loader.sv

// File: tutor_loader_top.sv
/*
 * Tutor cartridge and system-ROM loader
 * Download mapping, ROM identification, cartridge RAM checks, developer
 * bank enables, cartridge RAM erase and core reset generation
 */

`timescale 1ns/100ps
`default_nettype none

module tutor_loader_top import tutor_pkg::*; (
	input  wire             clk_sys,
	input  wire             RESET,
	input  wire load_port_t load_i,
	input  wire key_event_t key_i,
	input  wire menu_req_t  menu_i,
	output ram_wr_t         ram_wr_o,
	output sys_type_e       sys_type_o,
	output logic            rom_valid_o,
	output byte_addr_t      cart_last_o,
	output bank_en_t        bank_en_o,
	output logic            erase_busy_o,
	output logic            core_reset_o
);

	logic    cart_ram_en;
	ram_wr_t erase_wr;

	//////////////////////////////////////////////////
	// ROM and cartridge identification
	//////////////////////////////////////////////////

	rom_identify i_rom_identify (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.load_i        (load_i),
		.sys_type_o    (sys_type_o),
		.rom_valid_o   (rom_valid_o),
		.cart_last_o   (cart_last_o),
		.cart_ram_en_o (cart_ram_en)
	);

	bank_config i_bank_config (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.key_i         (key_i),
		.bank_req_i    (menu_i.bank_req),
		.cart_ram_en_i (cart_ram_en),
		.bank_en_o     (bank_en_o)
	);

	//////////////////////////////////////////////////
	// RAM write path
	//////////////////////////////////////////////////

	// Erase busy doubles as the port select
	cart_eraser i_cart_eraser (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.eject_req_i (menu_i.eject_req),
		.erase_wr_o  (erase_wr),
		.erasing_o   (erase_busy_o)
	);

	ram_load_port i_ram_load_port (
		.load_i     (load_i),
		.erase_wr_i (erase_wr),
		.erasing_i  (erase_busy_o),
		.ram_wr_o   (ram_wr_o)
	);

	// Core reset
	core_reset_gen i_core_reset_gen (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.reset_req_i  (menu_i.reset_req),
		.download_i   (load_i.download),
		.erasing_i    (erase_busy_o),
		.rom_valid_i  (rom_valid_o),
		.core_reset_o (core_reset_o)
	);

endmodule

`default_nettype wire

// File: tutor_pkg.sv
/*
 * Tutor loader types
 * Vector widths, state encodings and the bundled port structs
 */

`default_nettype none

package tutor_pkg;

	// Plain vector widths
	typedef logic [16:0] byte_addr_t;
	typedef logic [24:0] load_addr_t;
	typedef logic [15:0] rom_hash_t;
	typedef logic [7:0]  chk24_t;
	// Bit 0 is bank 4000, bit 4 is bank C000
	typedef logic [4:0]  bank_en_t;

	// Machine type, same encoding as the console's system_type input
	typedef enum logic [1:0] {
		SYS_TUTOR    = 2'd0,
		SYS_PYUTA    = 2'd1,
		SYS_PYUTA_JR = 2'd2,
		SYS_UNKNOWN  = 2'd3
	} sys_type_e;

	typedef enum logic [1:0] {
		ER_IDLE,
		ER_WRITE,
		ER_GAP
	} erase_state_e;

	//////////////////////////////////////////////////
	// Bundled ports
	//////////////////////////////////////////////////

	// Host download port, one byte per wr cycle
	typedef struct packed {
		logic       download;
		logic [7:0] index;
		logic       wr;
		load_addr_t addr;
		logic [7:0] data;
	} load_port_t;

	// Key event, new event on each change of toggle
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [7:0] code;
	} key_event_t;

	typedef struct packed {
		logic     reset_req;
		logic     eject_req;
		bank_en_t bank_req;
	} menu_req_t;

	// Byte write toward the external RAM
	typedef struct packed {
		logic       we;
		byte_addr_t addr;
		logic [7:0] data;
	} ram_wr_t;

endpackage

`default_nettype wire
